// ==== all.f ====
+incdir+logic
+incdir+bench
logic/cache_pkg.sv
logic/cache_req_decode.sv
logic/cache_way.sv
logic/way_select.sv
logic/cache_ctrl.sv
logic/data_cache.sv
bench/cache_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the data cache testbench with verilator and run it
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f all.f --top-module cache_tb -o cache_sim \
    && ./obj_dir/cache_sim > sim.log 2>&1
cat sim.log 2>/dev/null
# the log decides the result
grep -qx "TEST PASS" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// ==== bench/cache_model.svh ====
`ifndef CACHE_MODEL_SVH
`define CACHE_MODEL_SVH

// architectural word view, index is {line address, word}
logic [31:0]      arch_mem [1 << 16];
// per set residency, way order equals fill order
cache_pkg::tag_t  m_tag    [1 << `CACHE_SET_BITS][`CACHE_WAYS];
logic             m_valid  [1 << `CACHE_SET_BITS][`CACHE_WAYS];
logic             m_dirty  [1 << `CACHE_SET_BITS][`CACHE_WAYS];
logic [1:0]       m_ptr    [1 << `CACHE_SET_BITS];

// start pattern, odd multiplier so every address bit matters
function automatic logic [31:0] pattern_word(input logic [15:0] word_addr);
    return ({16'h0, word_addr} * 32'h9e37_79b1) ^ 32'h1234_5678;
endfunction

// word 0 in the top 32 bits
function automatic cache_pkg::line_t model_line(input cache_pkg::line_addr_t la);
    cache_pkg::line_t l;
    for (int w = 0; w < `CACHE_WORDS; w++)
    begin
        l[32*(`CACHE_WORDS-1-w) +: 32] = arch_mem[{la, 3'(w)}];
    end
    return l;
endfunction

// lane rule, offset 0 is the msb byte
function automatic logic [31:0] merge_store(input logic [31:0] old, input logic [1:0] size,
                                            input logic [1:0] off, input logic [31:0] wdata);
    logic [31:0] w;
    w = old;
    case (size)
        `SIZE_BYTE: w[31 - 8*int'(off) -: 8] = wdata[7:0];
        `SIZE_HALF:
        begin
            // odd offsets change nothing
            if (off == 2'd0)
            begin
                w[31:16] = wdata[15:0];
            end
            else if (off == 2'd2)
            begin
                w[15:0] = wdata[15:0];
            end
        end
        `SIZE_WORD: w = wdata;
        default: w = old;
    endcase
    return w;
endfunction

// -1 on a miss
function automatic int find_way(input logic [2:0] set, input cache_pkg::tag_t tag);
    int found;
    found = -1;
    for (int w = 0; w < `CACHE_WAYS; w++)
    begin
        if (m_valid[set][w] && m_tag[set][w] == tag)
        begin
            found = w;
        end
    end
    return found;
endfunction

task automatic check_value(input string name, input logic [269:0] expected,
                           input logic [269:0] actual);
    if (expected !== actual)
    begin
        $display("ERROR at %0t: %s expected %h got %h", $time, name, expected, actual);
        fail_run("a checked value did not match the model");
    end
endtask

`endif

// ==== bench/cache_tb.sv ====
`timescale 1ns/1ps
`include "cache_macros.svh"

module cache_tb;

    localparam int num_requests = 300;
    localparam int wait_limit   = 200;

    logic                clk;
    logic                rst;
    logic                cpu_req_valid_i;
    cache_pkg::cpu_req_t cpu_req_i;
    logic                cpu_ack_o;
    cache_pkg::word_t    cpu_rdata_o;
    logic                mem_req_valid_o;
    cache_pkg::mem_req_t mem_req_o;
    logic                mem_ack_i;
    cache_pkg::line_t    mem_rdata_i;

    // backing store behind the cache
    cache_pkg::line_t    phys_mem [1 << 13];
    // transfers seen by the responder during one request
    cache_pkg::mem_req_t mem_log [$];
    int                  mem_delay;
    logic [31:0]         lfsr_state;

    `include "cache_model.svh"

    data_cache dut_i
    (
        .clk             (clk),
        .rst             (rst),
        .cpu_req_valid_i (cpu_req_valid_i),
        .cpu_req_i       (cpu_req_i),
        .cpu_ack_o       (cpu_ack_o),
        .cpu_rdata_o     (cpu_rdata_o),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_req_o       (mem_req_o),
        .mem_ack_i       (mem_ack_i),
        .mem_rdata_i     (mem_rdata_i)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped");
    endtask

    // galois lfsr stepped once per bit taken
    function automatic logic [31:0] draw_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++)
        begin
            val = {val[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003)
                                       : (lfsr_state >> 1);
        end
        return val;
    endfunction

    // six tags over eight sets of four ways forces evictions
    function automatic cache_pkg::tag_t pick_tag(input int k);
        case (k)
            0: return 10'h000;
            1: return 10'h3ff;
            2: return 10'h155;
            3: return 10'h2aa;
            4: return 10'h0f3;
            default: return 10'h1c8;
        endcase
    endfunction

    task automatic wait_ack(input logic level);
        int cycles;
        cycles = 0;
        while (cpu_ack_o !== level)
        begin
            @(negedge clk);
            cycles++;
            if (cycles > wait_limit)
            begin
                fail_run(level ? "timeout, cpu_ack_o never rose"
                               : "timeout, cpu_ack_o never fell");
            end
        end
    endtask

    // memory responder waits 0 to 3 cycles before each ack
    always @(negedge clk)
    begin : responder
        logic [31:0] r;
        if (rst)
        begin
            mem_ack_i = 1'b0;
            mem_delay = -1;
        end
        else if (mem_ack_i)
        begin
            if (!mem_req_valid_o)
            begin
                mem_ack_i = 1'b0;
            end
        end
        else if (mem_req_valid_o)
        begin
            if (mem_delay < 0)
            begin
                r = draw_bits(2);
                mem_delay = int'(r[1:0]);
            end
            if (mem_delay == 0)
            begin
                mem_log.push_back(mem_req_o);
                if (mem_req_o.write)
                begin
                    phys_mem[mem_req_o.addr] = mem_req_o.line;
                end
                else
                begin
                    mem_rdata_i = phys_mem[mem_req_o.addr];
                end
                mem_ack_i = 1'b1;
                mem_delay = -1;
            end
            else
            begin
                mem_delay--;
            end
        end
    end

    task automatic run_request();
        logic [31:0]           r;
        logic                  write;
        cache_pkg::tag_t       tag;
        logic [2:0]            set;
        logic [2:0]            widx;
        logic [1:0]            off;
        logic [1:0]            size;
        logic [31:0]           wdata;
        logic [13:0]           upper;
        cache_pkg::line_addr_t la;
        cache_pkg::line_addr_t wb_addr;
        cache_pkg::line_t      wb_line;
        logic                  exp_wb;
        int                    hit_way;
        int                    victim;
        r = draw_bits(1);
        write = r[0];
        r = draw_bits(3);
        tag = pick_tag(int'(r[2:0]) % 6);
        r = draw_bits(3);
        set = r[2:0];
        r = draw_bits(3);
        widx = r[2:0];
        r = draw_bits(2);
        off = r[1:0];
        r = draw_bits(2);
        size = r[1:0];
        r = draw_bits(32);
        wdata = r;
        // bits above the tag are noise to the cache
        r = draw_bits(14);
        upper = r[13:0];
        la = {tag, set};

        // victim is the way the set pointer names
        hit_way = find_way(set, tag);
        victim  = int'(m_ptr[set]);
        exp_wb  = (hit_way < 0) && m_valid[set][victim] && m_dirty[set][victim];
        wb_addr = {m_tag[set][victim], set};
        wb_line = model_line(wb_addr);
        mem_log.delete();

        @(negedge clk);
        cpu_req_i.write = write;
        cpu_req_i.size  = size;
        cpu_req_i.addr  = {upper, tag, set, widx, off};
        cpu_req_i.wdata = wdata;
        cpu_req_valid_i = 1'b1;
        wait_ack(1'b1);

        if (hit_way < 0)
        begin
            check_value("memory transfer count", exp_wb ? 2 : 1, mem_log.size());
            if (exp_wb)
            begin
                check_value("write-back mem_req_o.write", 1, mem_log[0].write);
                check_value("write-back mem_req_o.addr", wb_addr, mem_log[0].addr);
                check_value("write-back mem_req_o.line", wb_line, mem_log[0].line);
            end
            check_value("fill mem_req_o.write", 0, mem_log[mem_log.size()-1].write);
            check_value("fill mem_req_o.addr", la, mem_log[mem_log.size()-1].addr);
            m_tag[set][victim]   = tag;
            m_valid[set][victim] = 1'b1;
            m_dirty[set][victim] = 1'b0;
            m_ptr[set]           = m_ptr[set] + 2'd1;
        end
        else
        begin
            check_value("memory transfer count", 0, mem_log.size());
        end

        if (write)
        begin
            // any store marks the line dirty
            arch_mem[{la, widx}] = merge_store(arch_mem[{la, widx}], size, off, wdata);
            m_dirty[set][find_way(set, tag)] = 1'b1;
        end
        else
        begin
            check_value("cpu_rdata_o", arch_mem[{la, widx}], cpu_rdata_o);
        end

        cpu_req_valid_i = 1'b0;
        wait_ack(1'b0);
    endtask

    initial
    begin
        cpu_req_valid_i = 1'b0;
        cpu_req_i       = '0;
        mem_ack_i       = 1'b0;
        mem_rdata_i     = '0;
        mem_delay       = -1;
        rst             = 1'b1;
        lfsr_state      = 32'd99917;

        for (int a = 0; a < (1 << 16); a++)
        begin
            arch_mem[a] = pattern_word(16'(a));
        end
        for (int l = 0; l < (1 << 13); l++)
        begin
            phys_mem[l] = model_line(13'(l));
        end
        for (int s = 0; s < (1 << `CACHE_SET_BITS); s++)
        begin
            m_ptr[s] = 2'd0;
            for (int w = 0; w < `CACHE_WAYS; w++)
            begin
                m_tag[s][w]   = '0;
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
            end
        end

        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // quiet bus after reset
        repeat (4)
        begin
            @(negedge clk);
            check_value("cpu_ack_o", 0, cpu_ack_o);
            check_value("mem_req_valid_o", 0, mem_req_valid_o);
        end

        for (int n = 0; n < num_requests; n++)
        begin
            run_request();
        end

        $display("TEST PASS");
        $finish;
    end

endmodule

// ==== logic/data_cache.sv ====
`timescale 1ns/1ps
`include "cache_macros.svh"

module data_cache
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cpu_req_valid_i,
    input  cache_pkg::cpu_req_t  cpu_req_i,
    output logic                 cpu_ack_o,
    output cache_pkg::word_t     cpu_rdata_o,
    output logic                 mem_req_valid_o,
    output cache_pkg::mem_req_t  mem_req_o,
    input  logic                 mem_ack_i,
    input  cache_pkg::line_t     mem_rdata_i
);

    // decoded request
    cache_pkg::set_idx_t             set;
    cache_pkg::tag_t                 tag;
    cache_pkg::word_idx_t            word_idx;
    cache_pkg::byte_mask_t           byte_mask;
    cache_pkg::word_t                store_word;

    // per way outputs
    cache_pkg::way_mask_t            hit_vec;
    cache_pkg::way_mask_t            valid_vec;
    cache_pkg::way_mask_t            dirty_vec;
    cache_pkg::word_t                way_rd_words [`CACHE_WAYS];
    cache_pkg::line_t                way_lines [`CACHE_WAYS];
    cache_pkg::tag_t                 way_tags [`CACHE_WAYS];

    // merged way view for the controller
    logic                            hit;
    cache_pkg::way_mask_t            hit_way;
    cache_pkg::word_t                rd_word;
    logic                            victim_dirty;
    cache_pkg::line_t                victim_line;
    cache_pkg::tag_t                 victim_tag;

    // controller strobes
    logic [$clog2(`CACHE_WAYS)-1:0]  victim;
    cache_pkg::way_mask_t            store_vec;
    cache_pkg::way_mask_t            fill_vec;

    cache_req_decode decode_i
    (
        .cpu_req_i    (cpu_req_i),
        .set_o        (set),
        .tag_o        (tag),
        .word_idx_o   (word_idx),
        .byte_mask_o  (byte_mask),
        .store_word_o (store_word)
    );

    for (genvar w = 0; w < `CACHE_WAYS; w++)
    begin : g_way
        cache_way way_i
        (
            .clk          (clk),
            .rst          (rst),
            .set_i        (set),
            .tag_i        (tag),
            .word_idx_i   (word_idx),
            .byte_mask_i  (byte_mask),
            .store_word_i (store_word),
            .store_i      (store_vec[w]),
            .fill_i       (fill_vec[w]),
            .fill_line_i  (mem_rdata_i),
            .hit_o        (hit_vec[w]),
            .rd_word_o    (way_rd_words[w]),
            .valid_o      (valid_vec[w]),
            .dirty_o      (dirty_vec[w]),
            .tag_o        (way_tags[w]),
            .line_o       (way_lines[w])
        );
    end

    way_select select_i
    (
        .hit_vec_i      (hit_vec),
        .valid_vec_i    (valid_vec),
        .dirty_vec_i    (dirty_vec),
        .rd_words_i     (way_rd_words),
        .lines_i        (way_lines),
        .tags_i         (way_tags),
        .victim_i       (victim),
        .hit_o          (hit),
        .hit_way_o      (hit_way),
        .rd_word_o      (rd_word),
        .victim_dirty_o (victim_dirty),
        .victim_line_o  (victim_line),
        .victim_tag_o   (victim_tag)
    );

    cache_ctrl ctrl_i
    (
        .clk             (clk),
        .rst             (rst),
        .cpu_req_valid_i (cpu_req_valid_i),
        .cpu_req_i       (cpu_req_i),
        .set_i           (set),
        .hit_i           (hit),
        .hit_way_i       (hit_way),
        .rd_word_i       (rd_word),
        .victim_dirty_i  (victim_dirty),
        .victim_line_i   (victim_line),
        .victim_tag_i    (victim_tag),
        .mem_ack_i       (mem_ack_i),
        .cpu_ack_o       (cpu_ack_o),
        .cpu_rdata_o     (cpu_rdata_o),
        .victim_o        (victim),
        .store_o         (store_vec),
        .fill_o          (fill_vec),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_req_o       (mem_req_o)
    );

endmodule

// ==== logic/cache_ctrl.sv ====
`timescale 1ns/1ps
`include "cache_macros.svh"

module cache_ctrl
(
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            cpu_req_valid_i,
    input  cache_pkg::cpu_req_t             cpu_req_i,
    input  cache_pkg::set_idx_t             set_i,
    input  logic                            hit_i,
    input  cache_pkg::way_mask_t            hit_way_i,
    input  cache_pkg::word_t                rd_word_i,
    input  logic                            victim_dirty_i,
    input  cache_pkg::line_t                victim_line_i,
    input  cache_pkg::tag_t                 victim_tag_i,
    input  logic                            mem_ack_i,
    output logic                            cpu_ack_o,
    output cache_pkg::word_t                cpu_rdata_o,
    output logic [$clog2(`CACHE_WAYS)-1:0]  victim_o,
    output cache_pkg::way_mask_t            store_o,
    output cache_pkg::way_mask_t            fill_o,
    output logic                            mem_req_valid_o,
    output cache_pkg::mem_req_t             mem_req_o
);

    localparam int tag_lsb = 2 + `CACHE_LINE_BITS + `CACHE_SET_BITS;
    localparam int sets    = 1 << `CACHE_SET_BITS;

    cache_pkg::ctrl_state_t          state_q;
    logic [$clog2(`CACHE_WAYS)-1:0]  ptr_q [sets];
    logic                            ack_q;
    cache_pkg::word_t                rdata_q;
    cache_pkg::mem_req_t             mem_req_q;
    cache_pkg::mem_req_t             wb_req;
    cache_pkg::mem_req_t             fill_req;
    logic                            lookup_req;

    assign lookup_req = (state_q == cache_pkg::LOOKUP) && cpu_req_valid_i;

    // round-robin pointer of the addressed set names the victim
    assign victim_o = ptr_q[set_i];

    // write-back of the victim line, upper address bits zero
    assign wb_req.write = 1'b1;
    assign wb_req.addr  = {victim_tag_i, set_i};
    assign wb_req.line  = victim_line_i;

    // fill of the requested line
    assign fill_req.write = 1'b0;
    assign fill_req.addr  = {cpu_req_i.addr[tag_lsb +: `CACHE_TAG_BITS], set_i};
    assign fill_req.line  = '0;

    // store lands in the hitting way at the ack edge
    assign store_o = (lookup_req && hit_i && cpu_req_i.write) ? hit_way_i : '0;
    // fill lands when memory acks the read
    assign fill_o  = (state_q == cache_pkg::FILL && mem_ack_i)
                   ? cache_pkg::way_mask_t'(1) << victim_o : '0;

    assign mem_req_valid_o = (state_q == cache_pkg::WRITE_BACK) || (state_q == cache_pkg::FILL);
    assign mem_req_o       = mem_req_q;
    assign cpu_ack_o       = ack_q;
    assign cpu_rdata_o     = rdata_q;

    // payload registers
    always_ff @(posedge clk)
    begin
        if (lookup_req && hit_i && !cpu_req_i.write)
        begin
            rdata_q <= rd_word_i;
        end
        if (lookup_req && !hit_i)
        begin
            mem_req_q <= victim_dirty_i ? wb_req : fill_req;
        end
        else if (state_q == cache_pkg::WB_RELEASE && !mem_ack_i)
        begin
            mem_req_q <= fill_req;
        end
    end

    // miss sequencing and cpu handshake
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state_q <= cache_pkg::LOOKUP;
            ack_q   <= 1'b0;
            for (int s = 0; s < sets; s++)
            begin
                ptr_q[s] <= '0;
            end
        end
        else
        begin
            case (state_q)
                cache_pkg::LOOKUP:
                begin
                    if (cpu_req_valid_i)
                    begin
                        if (hit_i)
                        begin
                            ack_q   <= 1'b1;
                            state_q <= cache_pkg::DONE;
                        end
                        else if (victim_dirty_i)
                        begin
                            state_q <= cache_pkg::WRITE_BACK;
                        end
                        else
                        begin
                            state_q <= cache_pkg::FILL;
                        end
                    end
                end
                cache_pkg::WRITE_BACK:
                begin
                    if (mem_ack_i)
                    begin
                        state_q <= cache_pkg::WB_RELEASE;
                    end
                end
                cache_pkg::WB_RELEASE:
                begin
                    // wait for memory to drop ack before the fill
                    if (!mem_ack_i)
                    begin
                        state_q <= cache_pkg::FILL;
                    end
                end
                cache_pkg::FILL:
                begin
                    if (mem_ack_i)
                    begin
                        // 2-bit pointer wraps modulo 4
                        ptr_q[set_i] <= ptr_q[set_i] + 1'b1;
                        state_q      <= cache_pkg::FILL_RELEASE;
                    end
                end
                cache_pkg::FILL_RELEASE:
                begin
                    // back to lookup, the request hits there
                    if (!mem_ack_i)
                    begin
                        state_q <= cache_pkg::LOOKUP;
                    end
                end
                cache_pkg::DONE:
                begin
                    if (!cpu_req_valid_i)
                    begin
                        ack_q   <= 1'b0;
                        state_q <= cache_pkg::LOOKUP;
                    end
                end
                default:
                begin
                    state_q <= cache_pkg::LOOKUP;
                end
            endcase
        end
    end

    // memory sees a steady request until it acks
    a_mem_req_stable: assert property (@(posedge clk) disable iff (rst)
        (mem_req_valid_o && !mem_ack_i) |=> $stable(mem_req_o));

endmodule

// ==== logic/way_select.sv ====
`timescale 1ns/1ps
`include "cache_macros.svh"

module way_select
(
    input  cache_pkg::way_mask_t            hit_vec_i,
    input  cache_pkg::way_mask_t            valid_vec_i,
    input  cache_pkg::way_mask_t            dirty_vec_i,
    input  cache_pkg::word_t                rd_words_i [`CACHE_WAYS],
    input  cache_pkg::line_t                lines_i [`CACHE_WAYS],
    input  cache_pkg::tag_t                 tags_i [`CACHE_WAYS],
    input  logic [$clog2(`CACHE_WAYS)-1:0]  victim_i,
    output logic                            hit_o,
    output cache_pkg::way_mask_t            hit_way_o,
    output cache_pkg::word_t                rd_word_o,
    output logic                            victim_dirty_o,
    output cache_pkg::line_t                victim_line_o,
    output cache_pkg::tag_t                 victim_tag_o
);

    assign hit_o     = |hit_vec_i;
    assign hit_way_o = hit_vec_i;

    // and-or mux over the hitting way
    always_comb
    begin
        rd_word_o = '0;
        for (int w = 0; w < `CACHE_WAYS; w++)
        begin
            if (hit_vec_i[w])
            begin
                rd_word_o = rd_word_o | rd_words_i[w];
            end
        end
    end

    // victim way picked by the set's round-robin pointer
    assign victim_line_o  = lines_i[victim_i];
    assign victim_tag_o   = tags_i[victim_i];
    // an invalid victim never needs a write-back
    assign victim_dirty_o = dirty_vec_i[victim_i] && valid_vec_i[victim_i];

    // a tag lives in at most one way of a set, so at most one way hits
    always_comb
    begin
        assert ($isunknown(hit_vec_i) || $onehot0(hit_vec_i))
        else $error("way_select: more than one way hit, vector %b", hit_vec_i);
    end

endmodule

// ==== logic/cache_way.sv ====
`timescale 1ns/1ps
`include "cache_macros.svh"

module cache_way
(
    input  logic                   clk,
    input  logic                   rst,
    input  cache_pkg::set_idx_t    set_i,
    input  cache_pkg::tag_t        tag_i,
    input  cache_pkg::word_idx_t   word_idx_i,
    input  cache_pkg::byte_mask_t  byte_mask_i,
    input  cache_pkg::word_t       store_word_i,
    input  logic                   store_i,
    input  logic                   fill_i,
    input  cache_pkg::line_t       fill_line_i,
    output logic                   hit_o,
    output cache_pkg::word_t       rd_word_o,
    output logic                   valid_o,
    output logic                   dirty_o,
    output cache_pkg::tag_t        tag_o,
    output cache_pkg::line_t       line_o
);

    localparam int sets = 1 << `CACHE_SET_BITS;

    // per set storage of this way
    cache_pkg::tag_t  tag_q  [sets];
    cache_pkg::line_t data_q [sets];
    logic [sets-1:0]  valid_q;
    logic [sets-1:0]  dirty_q;

    cache_pkg::line_t cur_line;
    cache_pkg::word_t merged_word;
    cache_pkg::line_t merged_line;

    assign cur_line = data_q[set_i];
    assign line_o   = cur_line;
    assign tag_o    = tag_q[set_i];
    assign valid_o  = valid_q[set_i];
    assign dirty_o  = dirty_q[set_i];

    // tag compare for the addressed set
    assign hit_o     = valid_q[set_i] && (tag_q[set_i] == tag_i);
    assign rd_word_o = cur_line[32*(`CACHE_WORDS-1-int'(word_idx_i)) +: 32];

    // byte merge of the store into the current word
    always_comb
    begin
        for (int b = 0; b < 4; b++)
        begin
            merged_word[8*b +: 8] = byte_mask_i[b] ? store_word_i[8*b +: 8]
                                                   : rd_word_o[8*b +: 8];
        end
        merged_line = cur_line;
        merged_line[32*(`CACHE_WORDS-1-int'(word_idx_i)) +: 32] = merged_word;
    end

    // line data and tags
    always_ff @(posedge clk)
    begin
        if (fill_i)
        begin
            data_q[set_i] <= fill_line_i;
            tag_q[set_i]  <= tag_i;
        end
        else if (store_i)
        begin
            data_q[set_i] <= merged_line;
        end
    end

    // status bits
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            valid_q <= '0;
            dirty_q <= '0;
        end
        else if (fill_i)
        begin
            valid_q[set_i] <= 1'b1;
            dirty_q[set_i] <= 1'b0;
        end
        else if (store_i)
        begin
            // marked dirty even when the mask is empty
            dirty_q[set_i] <= 1'b1;
        end
    end

    // store and fill strobes come from different controller states
    a_store_fill_excl: assert property (@(posedge clk) disable iff (rst)
        !(store_i && fill_i));

endmodule

// ==== logic/cache_req_decode.sv ====
`timescale 1ns/1ps
`include "cache_macros.svh"

module cache_req_decode
(
    input  cache_pkg::cpu_req_t   cpu_req_i,
    output cache_pkg::set_idx_t   set_o,
    output cache_pkg::tag_t       tag_o,
    output cache_pkg::word_idx_t  word_idx_o,
    output cache_pkg::byte_mask_t byte_mask_o,
    output cache_pkg::word_t      store_word_o
);

    // address layout: tag | set | word | byte
    localparam int word_lsb = 2;
    localparam int set_lsb  = word_lsb + `CACHE_LINE_BITS;
    localparam int tag_lsb  = set_lsb + `CACHE_SET_BITS;

    logic [1:0] byte_off;

    assign byte_off   = cpu_req_i.addr[word_lsb-1:0];
    assign word_idx_o = cpu_req_i.addr[set_lsb-1:word_lsb];
    assign set_o      = cpu_req_i.addr[tag_lsb-1:set_lsb];
    // upper address bits beyond the tag are dropped here
    assign tag_o      = cpu_req_i.addr[tag_lsb +: `CACHE_TAG_BITS];

    // mask bit 3 is the msb byte, i.e. byte offset 0
    // data is replicated so every lane carries the store value
    always_comb
    begin
        byte_mask_o  = '0;
        store_word_o = cpu_req_i.wdata;
        case (cpu_req_i.size)
            `SIZE_BYTE:
            begin
                byte_mask_o  = 4'b1000 >> byte_off;
                store_word_o = {4{cpu_req_i.wdata[7:0]}};
            end
            `SIZE_HALF:
            begin
                store_word_o = {2{cpu_req_i.wdata[15:0]}};
                // odd offsets leave the mask empty
                if (byte_off == 2'd0)
                begin
                    byte_mask_o = 4'b1100;
                end
                else if (byte_off == 2'd2)
                begin
                    byte_mask_o = 4'b0011;
                end
            end
            `SIZE_WORD:
            begin
                byte_mask_o = 4'b1111;
            end
            default:
            begin
                byte_mask_o = '0;
            end
        endcase
    end

endmodule

// ==== logic/cache_pkg.sv ====
`include "cache_macros.svh"

package cache_pkg;

    typedef logic [31:0]                                  word_t;
    typedef logic [`CACHE_TAG_BITS-1:0]                   tag_t;
    typedef logic [`CACHE_SET_BITS-1:0]                   set_idx_t;
    typedef logic [`CACHE_LINE_BITS-1:0]                  word_idx_t;
    typedef logic [3:0]                                   byte_mask_t;
    // word 0 of the line sits in the top 32 bits
    typedef logic [`CACHE_WORDS*32-1:0]                   line_t;
    typedef logic [`CACHE_WAYS-1:0]                       way_mask_t;
    typedef logic [1:0]                                   store_size_t;
    // line granular address, tag above set
    typedef logic [`CACHE_TAG_BITS+`CACHE_SET_BITS-1:0]   line_addr_t;

    // one cpu access, held stable while req is up
    typedef struct packed {
        logic        write;
        store_size_t size;
        logic [31:0] addr;
        word_t       wdata;
    } cpu_req_t;

    // one memory transfer, write-back or fill
    typedef struct packed {
        logic       write;
        line_addr_t addr;
        line_t      line;
    } mem_req_t;

    typedef enum logic [2:0] {
        LOOKUP,
        WRITE_BACK,
        WB_RELEASE,
        FILL,
        FILL_RELEASE,
        DONE
    } ctrl_state_t;

endpackage

// ==== logic/cache_macros.svh ====
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// cache geometry
// 4 ways, 8 sets, 8 words per line
`define CACHE_WAYS      4
`define CACHE_SET_BITS  3
`define CACHE_LINE_BITS 3
`define CACHE_TAG_BITS  10
`define CACHE_WORDS     8

// store size codes carried in cpu_req_t.size
`define SIZE_BYTE 2'd0
`define SIZE_HALF 2'd1
`define SIZE_WORD 2'd2

`endif
